//--- logic/tm1638_pkg.sv
// opcode enum, request and status structs, tm1638 command bytes, register offsets
package tm1638_pkg;

	// request kinds written by the host into REQ[2:0]
	typedef enum logic [2:0] {
		OP_CMD     = 3'd0, // raw command byte
		OP_SEG7    = 3'd1, // one digit
		OP_LED     = 3'd2, // one led
		OP_ALL_LED = 3'd3, // eight leds from a bitmap
		OP_BTN     = 3'd4  // key scan
	} tm1638_op_e;

	// one request from the register block to the sequencer
	typedef struct packed {
		tm1638_op_e op;
		logic [2:0] idx;   // digit or led index
		logic [7:0] data;  // segments, led value, bitmap or raw command
		logic [7:0] spare; // kept at zero
	} tm1638_req_t;

	// host-visible status word
	typedef struct packed {
		logic       idle; // no request in flight
		logic [7:0] btn;  // 1 = pressed
	} tm1638_status_t;

	// chip command bytes
	localparam logic [7:0] TM_CMD_READ_KEYS = 8'h42;
	localparam logic [7:0] TM_ADDR_BASE     = 8'hc0; // digit 0
	localparam logic [7:0] TM_ADDR_LED_BASE = 8'hc1; // led 0

	// strobe hold counter width
	localparam int TM_WAIT_W = 28;

	// axi4-lite register map, byte offsets
	localparam logic [3:0] TM_REG_REQ    = 4'h0;
	localparam logic [3:0] TM_REG_WAIT   = 4'h4;
	localparam logic [3:0] TM_REG_STATUS = 4'h8;

endpackage

//--- logic/tm1638_serial.sv
// tm1638_serial: bit-level engine, one byte out or four key bytes in, button decode
`timescale 1ns/100ps

module tm1638_serial
#(
	parameter int CLK_DIV = 4 // i_clk cycles per half serial clock
)
(
	input  logic       i_clk,
	input  logic       i_arst_n,
	input  logic       i_wr_en,   // one-cycle pulse, send i_wr_byte
	input  logic [7:0] i_wr_byte,
	input  logic       i_rd_en,   // one-cycle pulse, read 4 key bytes
	input  logic       i_dio,
	output logic       o_idle,
	output logic [7:0] o_btn,     // held until the next read
	output logic       o_sclk,
	output logic       o_dio,
	output logic       o_dio_oe
);

localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

logic             busy;
logic             reading;  // current transfer is a key read
logic [DIV_W-1:0] div_cnt;
logic [4:0]       bit_cnt;
logic [7:0]       tx_sr;
logic [31:0]      rx_sr;
logic [7:0]       key_mask;
logic             start;
logic             half_end; // last cycle of a half period
logic             last_bit;

assign o_idle   = ~busy;
assign start    = ~busy & (i_wr_en | i_rd_en);
assign half_end = busy & (div_cnt == DIV_LAST);
assign last_bit = reading ? (bit_cnt == 5'd31) : (bit_cnt == 5'd7);

// key byte k: bit 0 is button k, bit 4 is button k+4
always_comb begin
	for (int k = 0; k < 4; k++) begin
		key_mask[k]     = rx_sr[8*k];
		key_mask[k + 4] = rx_sr[8*k + 4];
	end
end

always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		busy     <= 1'b0;
		reading  <= 1'b0;
		div_cnt  <= '0;
		bit_cnt  <= '0;
		o_sclk   <= 1'b1;
		o_dio    <= 1'b1;
		o_dio_oe <= 1'b1;
		o_btn    <= '0;
	end else if (start) begin
		busy     <= 1'b1;
		reading  <= ~i_wr_en;                          // write wins if both pulse
		div_cnt  <= '0;
		bit_cnt  <= '0;
		o_sclk   <= 1'b0;                              // first low half
		o_dio_oe <= i_wr_en;                           // release pin for reads
		o_dio    <= i_wr_en ? i_wr_byte[0] : 1'b1;     // lsb first
	end else if (busy) begin
		div_cnt <= half_end ? '0 : div_cnt + 1'b1;
		if (half_end) begin
			if (!o_sclk) begin
				o_sclk <= 1'b1;                         // chip samples here
			end else if (last_bit) begin
				busy     <= 1'b0;                       // sclk stays high
				o_dio    <= 1'b1;
				o_dio_oe <= 1'b1;
				if (reading)
					o_btn <= key_mask;
			end else begin
				o_sclk  <= 1'b0;
				bit_cnt <= bit_cnt + 1'b1;
				if (!reading)
					o_dio <= tx_sr[1];                  // next bit while clock low
			end
		end
	end
end

// shift registers, no reset needed
always_ff @(posedge i_clk) begin
	if (start)
		tx_sr <= i_wr_byte;
	else if (half_end && o_sclk && !last_bit)
		tx_sr <= {1'b0, tx_sr[7:1]};

	if (half_end && !o_sclk && reading)
		rx_sr <= {i_dio, rx_sr[31:1]};                  // sample on rising edge
end

endmodule

//--- logic/tm1638_led_key.sv
// tm1638_led_key: request sequencer, strobe framing, address bytes, strobe hold time
`timescale 1ns/100ps

module tm1638_led_key
	import tm1638_pkg::*;
(
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	input  logic                 i_req_valid,
	input  tm1638_req_t          i_req,
	input  logic [TM_WAIT_W-1:0] i_wait,      // strobe hold after the request
	input  logic                 i_eng_idle,
	output logic                 o_req_ready,
	output logic                 o_wr_en,
	output logic [7:0]           o_wr_byte,
	output logic                 o_rd_en,
	output logic                 o_stb,
	output logic                 o_idle
);

typedef enum logic [2:0] {
	S_IDLE,
	S_START, // pull strobe low
	S_SEND,  // issue next byte
	S_GAP,   // engine picks up the pulse
	S_WAIT,  // wait for engine
	S_STOP,  // raise strobe
	S_HOLD   // strobe hold count
} state_e;

state_e               state;
tm1638_req_t          req_q;
logic [2:0]           frame;    // frame number for all-led
logic                 byte_sel; // 0 = first byte of the frame
logic                 reading;  // key read already issued
logic [TM_WAIT_W-1:0] hold_cnt;
logic [7:0]           first_byte;
logic [7:0]           second_byte;
logic                 two_bytes;
logic                 more_frames;

assign o_req_ready = (state == S_IDLE);
assign o_idle      = (state == S_IDLE) & ~i_req_valid & i_eng_idle;
assign more_frames = (req_q.op == OP_ALL_LED) && (frame != 3'd7);

// bytes of the current frame
always_comb begin
	first_byte  = req_q.data;
	second_byte = req_q.data;
	two_bytes   = 1'b1;
	case (req_q.op)
		OP_SEG7: begin
			first_byte = TM_ADDR_BASE + {4'b0, req_q.idx, 1'b0};
		end
		OP_LED: begin
			first_byte = TM_ADDR_LED_BASE + {4'b0, req_q.idx, 1'b0};
		end
		OP_ALL_LED: begin
			first_byte  = TM_ADDR_LED_BASE + {4'b0, frame, 1'b0};
			second_byte = {7'b0, req_q.data[frame]}; // led on/off
		end
		OP_BTN: begin
			first_byte = TM_CMD_READ_KEYS;
			two_bytes  = 1'b0;
		end
		default: begin
			two_bytes = 1'b0; // raw command, unknown ops too
		end
	endcase
end

always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		state    <= S_IDLE;
		o_stb    <= 1'b1;
		o_wr_en  <= 1'b0;
		o_rd_en  <= 1'b0;
		frame    <= '0;
		byte_sel <= 1'b0;
		reading  <= 1'b0;
		hold_cnt <= '0;
	end else begin
		o_wr_en <= 1'b0;
		o_rd_en <= 1'b0;
		case (state)
			S_IDLE: begin
				o_stb <= 1'b1;
				if (i_req_valid) begin
					frame    <= '0;
					reading  <= 1'b0;
					hold_cnt <= i_wait;
					state    <= S_START;
				end
			end
			S_START: begin
				o_stb    <= 1'b0;
				byte_sel <= 1'b0;
				state    <= S_SEND;
			end
			S_SEND: begin
				if (i_eng_idle) begin
					o_wr_en <= 1'b1;
					state   <= S_GAP;
				end
			end
			S_GAP: begin
				state <= S_WAIT; // engine idle drops after this cycle
			end
			S_WAIT: begin
				if (i_eng_idle) begin
					if (!byte_sel && two_bytes) begin
						byte_sel <= 1'b1;
						state    <= S_SEND;
					end else if (req_q.op == OP_BTN && !reading) begin
						reading <= 1'b1;
						o_rd_en <= 1'b1;   // key read in the same frame
						state   <= S_GAP;
					end else begin
						state <= S_STOP;
					end
				end
			end
			S_STOP: begin
				o_stb <= 1'b1;
				if (more_frames) begin
					frame <= frame + 1'b1;
					state <= S_START;
				end else begin
					state <= S_HOLD;
				end
			end
			S_HOLD: begin
				if (hold_cnt == '0)
					state <= S_IDLE;
				else
					hold_cnt <= hold_cnt - 1'b1;
			end
			default: state <= S_IDLE;
		endcase
	end
end

// request and byte payload
always_ff @(posedge i_clk) begin
	if (state == S_IDLE && i_req_valid)
		req_q <= i_req;
	if (state == S_SEND && i_eng_idle)
		o_wr_byte <= byte_sel ? second_byte : first_byte;
end

endmodule

//--- logic/tm1638_axil_regs.sv
// tm1638_axil_regs: axi4-lite slave with REQ, WAIT and STATUS registers
`timescale 1ns/100ps

module tm1638_axil_regs
	import tm1638_pkg::*;
#(
	parameter int unsigned TM_WAIT_RESET = 0 // reset value of WAIT
)
(
	input  logic                 i_clk,
	input  logic                 i_arst_n,
	// axi4-lite slave
	input  logic                 i_awvalid,
	output logic                 o_awready,
	input  logic [3:0]           i_awaddr,
	input  logic                 i_wvalid,
	output logic                 o_wready,
	input  logic [31:0]          i_wdata,
	input  logic [3:0]           i_wstrb,
	output logic                 o_bvalid,
	input  logic                 i_bready,
	output logic [1:0]           o_bresp,
	input  logic                 i_arvalid,
	output logic                 o_arready,
	input  logic [3:0]           i_araddr,
	output logic                 o_rvalid,
	input  logic                 i_rready,
	output logic [31:0]          o_rdata,
	output logic [1:0]           o_rresp,
	// towards the sequencer
	output logic                 o_req_valid,
	input  logic                 i_req_ready,
	output tm1638_req_t          o_req,
	output logic [TM_WAIT_W-1:0] o_wait,
	input  tm1638_status_t       i_status
);

logic        wr_go;      // aw and w taken together
logic        rd_go;
logic [31:0] wait_merge; // WAIT with byte strobes applied
logic [31:0] rd_word;

// no new write while a response or a request is outstanding
assign wr_go     = i_awvalid & i_wvalid & ~o_bvalid & ~o_req_valid;
assign o_awready = wr_go;
assign o_wready  = wr_go;
assign o_bresp   = 2'b00;
assign rd_go     = i_arvalid & o_arready;
assign o_arready = ~o_rvalid;
assign o_rresp   = 2'b00;

always_comb begin
	wait_merge = {{(32 - TM_WAIT_W){1'b0}}, o_wait};
	for (int b = 0; b < 4; b++) begin
		if (i_wstrb[b])
			wait_merge[8*b +: 8] = i_wdata[8*b +: 8];
	end
end

always_comb begin
	case (i_araddr)
		TM_REG_REQ:    rd_word = {16'h0, o_req.data, 1'b0, o_req.idx, 1'b0, o_req.op};
		TM_REG_WAIT:   rd_word = {{(32 - TM_WAIT_W){1'b0}}, o_wait};
		TM_REG_STATUS: rd_word = {16'h0, i_status.btn, 7'h0, i_status.idle};
		default:       rd_word = '0;
	endcase
end

always_ff @(posedge i_clk or negedge i_arst_n) begin
	if (!i_arst_n) begin
		o_bvalid    <= 1'b0;
		o_rvalid    <= 1'b0;
		o_req_valid <= 1'b0;
		o_req       <= '0;
		o_wait      <= TM_WAIT_W'(TM_WAIT_RESET);
	end else begin
		if (o_bvalid && i_bready)
			o_bvalid <= 1'b0;
		if (o_req_valid && i_req_ready)
			o_req_valid <= 1'b0;        // handshake done

		if (wr_go) begin
			o_bvalid <= 1'b1;
			case (i_awaddr)
				TM_REG_REQ: begin
					o_req_valid <= 1'b1;
					o_req.op    <= tm1638_op_e'(i_wdata[2:0]);
					o_req.idx   <= i_wdata[6:4];
					o_req.data  <= i_wdata[15:8];
					o_req.spare <= 8'h00;
				end
				TM_REG_WAIT: o_wait <= wait_merge[TM_WAIT_W-1:0];
				default: ;                  // ignored, still OKAY
			endcase
		end

		if (o_rvalid && i_rready)
			o_rvalid <= 1'b0;
		if (rd_go)
			o_rvalid <= 1'b1;
	end
end

// read data
always_ff @(posedge i_clk) begin
	if (rd_go)
		o_rdata <= rd_word;
end

endmodule

//--- logic/tm1638_shield_ctrl.sv
// tm1638_shield_ctrl: top level joining register block, sequencer and serial engine
`timescale 1ns/100ps

module tm1638_shield_ctrl
	import tm1638_pkg::*;
#(
	parameter int          CLK_DIV       = 4,
	parameter int unsigned TM_WAIT_RESET = 0
)
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  logic        i_awvalid,
	output logic        o_awready,
	input  logic [3:0]  i_awaddr,
	input  logic        i_wvalid,
	output logic        o_wready,
	input  logic [31:0] i_wdata,
	input  logic [3:0]  i_wstrb,
	output logic        o_bvalid,
	input  logic        i_bready,
	output logic [1:0]  o_bresp,
	input  logic        i_arvalid,
	output logic        o_arready,
	input  logic [3:0]  i_araddr,
	output logic        o_rvalid,
	input  logic        i_rready,
	output logic [31:0] o_rdata,
	output logic [1:0]  o_rresp,
	// shield pins
	output logic        o_tm1638_clk,
	output logic        o_tm1638_stb,
	output logic        o_tm1638_dio,
	output logic        o_tm1638_dio_oe, // drive enable for the board buffer
	input  logic        i_tm1638_dio
);

logic                 req_valid;
logic                 req_ready;
tm1638_req_t          req;
logic [TM_WAIT_W-1:0] wait_cnt;
tm1638_status_t       status;
logic                 seq_idle;
logic                 eng_idle;
logic                 wr_en;
logic [7:0]           wr_byte;
logic                 rd_en;
logic [7:0]           btn;

assign status = '{idle: seq_idle, btn: btn};

tm1638_axil_regs #(
	.TM_WAIT_RESET(TM_WAIT_RESET)
) i_tm1638_axil_regs (
	.i_clk       (i_clk),
	.i_arst_n    (i_arst_n),
	.i_awvalid   (i_awvalid),
	.o_awready   (o_awready),
	.i_awaddr    (i_awaddr),
	.i_wvalid    (i_wvalid),
	.o_wready    (o_wready),
	.i_wdata     (i_wdata),
	.i_wstrb     (i_wstrb),
	.o_bvalid    (o_bvalid),
	.i_bready    (i_bready),
	.o_bresp     (o_bresp),
	.i_arvalid   (i_arvalid),
	.o_arready   (o_arready),
	.i_araddr    (i_araddr),
	.o_rvalid    (o_rvalid),
	.i_rready    (i_rready),
	.o_rdata     (o_rdata),
	.o_rresp     (o_rresp),
	.o_req_valid (req_valid),
	.i_req_ready (req_ready),
	.o_req       (req),
	.o_wait      (wait_cnt),
	.i_status    (status)
);

tm1638_led_key i_tm1638_led_key (
	.i_clk       (i_clk),
	.i_arst_n    (i_arst_n),
	.i_req_valid (req_valid),
	.i_req       (req),
	.i_wait      (wait_cnt),
	.i_eng_idle  (eng_idle),
	.o_req_ready (req_ready),
	.o_wr_en     (wr_en),
	.o_wr_byte   (wr_byte),
	.o_rd_en     (rd_en),
	.o_stb       (o_tm1638_stb),
	.o_idle      (seq_idle)
);

tm1638_serial #(
	.CLK_DIV(CLK_DIV)
) i_tm1638_serial (
	.i_clk     (i_clk),
	.i_arst_n  (i_arst_n),
	.i_wr_en   (wr_en),
	.i_wr_byte (wr_byte),
	.i_rd_en   (rd_en),
	.i_dio     (i_tm1638_dio),
	.o_idle    (eng_idle),
	.o_btn     (btn),
	.o_sclk    (o_tm1638_clk),
	.o_dio     (o_tm1638_dio),
	.o_dio_oe  (o_tm1638_dio_oe)
);

endmodule

//--- verification/tb_clock_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/100ps

module tb_clock_gen
#(
	parameter int HALF_PERIOD = 20, // ns
	parameter int RESET_CYCLES = 2
)
(
	output logic o_clk,
	output logic o_arst_n
);

initial begin
	o_clk = 1'b0;
	forever #(HALF_PERIOD) o_clk = ~o_clk;
end

initial begin
	o_arst_n = 1'b0;
	repeat (RESET_CYCLES) @(posedge o_clk);
	#1 o_arst_n = 1'b1; // release just after the edge
end

endmodule

//--- verification/tm1638_chip_model.sv
// behavioural tm1638 shield model, frame recorder and key byte source
`timescale 1ns/100ps

module tm1638_chip_model (
	input  logic       i_stb,
	input  logic       i_sclk,
	input  logic       i_dio,  // controller data out
	input  logic [7:0] i_mask, // pressed buttons
	output logic       o_dio   // key data back to the controller
);

logic [7:0]  byte_q[$];         // written bytes of all frames in order
int          len_q[$];          // byte count per frame
logic [7:0]  sr = 8'h00;
int          bit_cnt = 0;
int          frame_len = 0;
logic        in_frame = 1'b0;
logic        reading = 1'b0;    // key bytes being shifted out
logic [31:0] keys = '0;
int          key_bit = 0;

initial o_dio = 1'b1;

// key byte k holds button k in bit 0 and button k+4 in bit 4
function automatic logic [31:0] key_bytes(input logic [7:0] mask);
	logic [31:0] w;
	w = '0;
	for (int k = 0; k < 4; k++) begin
		w[8*k]     = mask[k];
		w[8*k + 4] = mask[k + 4];
	end
	return w;
endfunction

always @(negedge i_stb) begin
	in_frame  = 1'b1;
	bit_cnt   = 0;
	frame_len = 0;
	reading   = 1'b0;
end

always @(posedge i_stb) begin
	if (in_frame)
		len_q.push_back(frame_len);
	in_frame = 1'b0;
	reading  = 1'b0;
	o_dio    = 1'b1;
end

// chip samples on the rising serial clock
always @(posedge i_sclk) begin
	if (i_stb === 1'b0 && !reading) begin
		sr = {i_dio, sr[7:1]};   // lsb first
		bit_cnt++;
		if (bit_cnt == 8) begin
			byte_q.push_back(sr);
			frame_len++;
			bit_cnt = 0;
			if (frame_len == 1 && sr == 8'h42) begin
				reading = 1'b1;
				keys    = key_bytes(i_mask);
				key_bit = 0;
			end
		end
	end
end

// next key bit goes out while the clock is low
always @(negedge i_sclk) begin
	if (i_stb === 1'b0 && reading && key_bit < 32) begin
		o_dio = keys[key_bit];
		key_bit++;
	end
end

endmodule

//--- verification/tb_tm1638_shield_ctrl.sv
// testbench top with axi4-lite host tasks, case file reader, expected frames and checks
`timescale 1ns/100ps

module tb_tm1638_shield_ctrl
	import tm1638_pkg::*;
();

localparam int CLK_DIV   = 2;
localparam int MAX_CASES = 64;

logic        clk;
logic        arst_n;
logic        awvalid;
logic        awready;
logic [3:0]  awaddr;
logic        wvalid;
logic        wready;
logic [31:0] wdata;
logic [3:0]  wstrb;
logic        bvalid;
logic        bready;
logic [1:0]  bresp;
logic        arvalid;
logic        arready;
logic [3:0]  araddr;
logic        rvalid;
logic        rready;
logic [31:0] rdata;
logic [1:0]  rresp;
logic        tm_clk;
logic        tm_stb;
logic        tm_dio;
logic        tm_dio_oe;
logic        tm_dio_in;
logic [7:0]  btn_mask = 8'h00; // buttons held down on the model

int c_op[MAX_CASES];
int c_idx[MAX_CASES];
int c_data[MAX_CASES];          // above ff means random
int c_wait[MAX_CASES];
int c_mask[MAX_CASES];
int c_back[MAX_CASES];          // issued while the previous request runs
int n_cases = 0;
int case_budget = 1000;
int cycle_limit = 0;
int cycle_cnt = 0;
int stb_rise_cycle = 0;
int stall_max = 0;
int value_errs = 0;
int frame_errs = 0;
int bus_errs = 0;
int timing_errs = 0;
int setup_errs = 0;

logic [7:0] exp_bytes[$];
int         exp_len[$];
int         frame_pos = 0;
int         got_pos = 0;
int         exp_pos = 0;
logic [7:0] exp_btn = 8'h00;

tb_clock_gen #(
	.HALF_PERIOD(20)
) i_tb_clock_gen (
	.o_clk    (clk),
	.o_arst_n (arst_n)
);

tm1638_shield_ctrl #(
	.CLK_DIV       (CLK_DIV),
	.TM_WAIT_RESET (0)
) i_tm1638_shield_ctrl (
	.i_clk           (clk),
	.i_arst_n        (arst_n),
	.i_awvalid       (awvalid),
	.o_awready       (awready),
	.i_awaddr        (awaddr),
	.i_wvalid        (wvalid),
	.o_wready        (wready),
	.i_wdata         (wdata),
	.i_wstrb         (wstrb),
	.o_bvalid        (bvalid),
	.i_bready        (bready),
	.o_bresp         (bresp),
	.i_arvalid       (arvalid),
	.o_arready       (arready),
	.i_araddr        (araddr),
	.o_rvalid        (rvalid),
	.i_rready        (rready),
	.o_rdata         (rdata),
	.o_rresp         (rresp),
	.o_tm1638_clk    (tm_clk),
	.o_tm1638_stb    (tm_stb),
	.o_tm1638_dio    (tm_dio),
	.o_tm1638_dio_oe (tm_dio_oe),
	.i_tm1638_dio    (tm_dio_in)
);

tm1638_chip_model i_tm1638_chip_model (
	.i_stb  (tm_stb),
	.i_sclk (tm_clk),
	.i_dio  (tm_dio),
	.i_mask (btn_mask),
	.o_dio  (tm_dio_in)
);

always @(posedge clk) cycle_cnt = cycle_cnt + 1;

always @(posedge tm_stb) stb_rise_cycle = cycle_cnt; // edge that raised the strobe

initial begin
	wait (cycle_limit > 0);
	wait (cycle_cnt > cycle_limit);
	$display("timeout: run went past %0d cycles", cycle_limit);
	$display("Something failed");
	$finish;
end

task automatic check_byte(input int frame, input int pos, input logic [7:0] got,
		input logic [7:0] exp);
	if (got !== exp) begin
		$display("CHECK FAILED o_tm1638_dio frame %0d byte %0d: got %h expected %h",
			frame, pos, got, exp);
		value_errs++;
	end
endtask

task automatic check_status(input tm1638_status_t got, input tm1638_status_t exp);
	if (got !== exp) begin
		$display("CHECK FAILED STATUS: got %h expected %h", got, exp);
		value_errs++;
	end
endtask

task automatic check_oe(input logic got, input logic exp);
	if (got !== exp) begin
		$display("CHECK FAILED o_tm1638_dio_oe: got %h expected %h", got, exp);
		value_errs++;
	end
endtask

// pin released only while key bytes come back
always @(negedge clk) begin
	if (tm_stb === 1'b0 && tm_clk === 1'b0)
		check_oe(tm_dio_oe, !i_tm1638_chip_model.reading);
end

task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
	int stall;
	stall   = 0;
	awaddr  = addr;
	wdata   = data;
	awvalid = 1'b1;
	wvalid  = 1'b1;
	@(negedge clk);
	while (!(awready && wready) && stall < case_budget) begin
		stall++;
		@(negedge clk);
	end
	if (!(awready && wready)) begin
		$display("AXI write to %h was not accepted within %0d cycles", addr, stall);
		bus_errs++;
	end
	if (stall > stall_max)
		stall_max = stall;
	@(posedge clk);
	#1;
	awvalid = 1'b0;
	wvalid  = 1'b0;
	stall   = 0;
	@(negedge clk);
	while (!bvalid && stall < 16) begin
		stall++;
		@(negedge clk);
	end
	if (!bvalid || bresp != 2'b00) begin
		$display("AXI write to %h got no OKAY response", addr);
		bus_errs++;
	end
	@(posedge clk);
	#1;
endtask

// sample_cyc is the edge at which the address was taken
task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
		output int sample_cyc);
	int stall;
	stall   = 0;
	araddr  = addr;
	arvalid = 1'b1;
	@(negedge clk);
	while (!arready && stall < 16) begin
		stall++;
		@(negedge clk);
	end
	sample_cyc = cycle_cnt + 1;
	@(posedge clk);
	#1;
	arvalid = 1'b0;
	stall   = 0;
	@(negedge clk);
	while (!rvalid && stall < 16) begin
		stall++;
		@(negedge clk);
	end
	if (!rvalid || rresp != 2'b00) begin
		$display("AXI read of %h returned no OKAY data", addr);
		bus_errs++;
	end
	data = rdata;
	@(posedge clk);
	#1;
endtask

task automatic push_frame(input int len, input logic [7:0] b0, input logic [7:0] b1);
	exp_len.push_back(len);
	exp_bytes.push_back(b0);
	if (len > 1)
		exp_bytes.push_back(b1);
endtask

// frames a request should put on the pins
task automatic expect_request(input logic [2:0] op, input logic [2:0] idx,
		input logic [7:0] data);
	case (tm1638_op_e'(op))
		OP_SEG7:    push_frame(2, 8'hc0 + 8'(2 * idx), data); // digit address
		OP_LED:     push_frame(2, 8'hc1 + 8'(2 * idx), data);
		OP_ALL_LED: begin
			for (int k = 0; k < 8; k++)
				push_frame(2, 8'hc1 + 8'(2 * k), data[k] ? 8'h01 : 8'h00);
		end
		OP_BTN:     push_frame(1, 8'h42, 8'h00);
		default:    push_frame(1, data, 8'h00);           // raw command
	endcase
endtask

task automatic compare_frames();
	int got_n;
	got_n = i_tm1638_chip_model.len_q.size();
	if (got_n != exp_len.size()) begin
		$display("recorded %0d frames, expected %0d", got_n, exp_len.size());
		frame_errs++;
	end
	while (frame_pos < got_n && frame_pos < exp_len.size()) begin
		if (i_tm1638_chip_model.len_q[frame_pos] != exp_len[frame_pos]) begin
			$display("frame %0d has %0d bytes, expected %0d", frame_pos,
				i_tm1638_chip_model.len_q[frame_pos], exp_len[frame_pos]);
			frame_errs++;
		end
		for (int b = 0; b < i_tm1638_chip_model.len_q[frame_pos] && b < exp_len[frame_pos];
				b++)
			check_byte(frame_pos, b, i_tm1638_chip_model.byte_q[got_pos + b],
				exp_bytes[exp_pos + b]);
		got_pos += i_tm1638_chip_model.len_q[frame_pos];
		exp_pos += exp_len[frame_pos];
		frame_pos++;
	end
endtask

// poll STATUS until idle, then check buttons and strobe hold
task automatic wait_idle(input int hold);
	logic [31:0]    word;
	int             sample_cyc;
	int             start;
	tm1638_status_t got;
	tm1638_status_t exp;
	word       = '0;
	sample_cyc = 0;
	start      = cycle_cnt;
	while (!word[0] && cycle_cnt - start < 4 * case_budget)
		axi_read(TM_REG_STATUS, word, sample_cyc);
	if (!word[0]) begin
		$display("request did not finish within %0d cycles", 4 * case_budget);
		timing_errs++;
	end else begin
		got = '{idle: word[0], btn: word[15:8]};
		exp = '{idle: 1'b1, btn: exp_btn};
		check_status(got, exp);
		if (sample_cyc - stb_rise_cycle < hold) begin
			$display("idle seen %0d cycles after the strobe rose, WAIT was %0d",
				sample_cyc - stb_rise_cycle, hold);
			timing_errs++;
		end
	end
endtask

initial begin
	int         fd;
	int         n;
	int         op;
	int         idx;
	int         dat;
	int         wt;
	int         msk;
	int         bk;
	int         max_wait;
	bit         chained;
	string      line;
	logic [7:0] data;
	awvalid  = 1'b0;
	awaddr   = 4'h0;
	wvalid   = 1'b0;
	wdata    = '0;
	wstrb    = 4'hf;
	bready   = 1'b1;
	arvalid  = 1'b0;
	araddr   = 4'h0;
	rready   = 1'b1;
	max_wait = 0;
	chained  = 1'b0;
	void'($urandom(14206));

	fd = $fopen("verification/tm1638_cases.txt", "r");
	if (fd == 0) begin
		$display("cannot open verification/tm1638_cases.txt");
		setup_errs++;
	end
	while (fd != 0 && !$feof(fd) && n_cases < MAX_CASES) begin
		line = "";
		void'($fgets(line, fd));
		n = $sscanf(line, "%h %h %h %h %h %h", op, idx, dat, wt, msk, bk);
		if (n == 6) begin                // comment and blank lines skipped
			c_op[n_cases]   = op;
			c_idx[n_cases]  = idx;
			c_data[n_cases] = dat;
			c_wait[n_cases] = wt;
			c_mask[n_cases] = msk;
			c_back[n_cases] = bk;
			if (wt > max_wait)
				max_wait = wt;
			if (bk != 0)
				chained = 1'b1;
			n_cases++;
		end
	end
	if (fd != 0)
		$fclose(fd);
	if (n_cases == 0) begin
		$display("no test cases were read");
		setup_errs++;
	end
	case_budget = 8 * 40 * CLK_DIV + max_wait + 200;
	cycle_limit = (n_cases + 1) * case_budget;

	wait (arst_n === 1'b1);
	@(posedge clk);
	#1;
	for (int i = 0; i < n_cases; i++) begin
		data     = (c_data[i] > 255) ? 8'($urandom()) : 8'(c_data[i]);
		btn_mask = 8'(c_mask[i]);
		axi_write(TM_REG_WAIT, 32'(c_wait[i]));
		axi_write(TM_REG_REQ, {16'h0, data, 1'b0, 3'(c_idx[i]), 1'b0, 3'(c_op[i])});
		expect_request(3'(c_op[i]), 3'(c_idx[i]), data);
		if (c_op[i] == 4)
			exp_btn = btn_mask;
		if (i + 1 >= n_cases || c_back[i + 1] == 0) begin
			wait_idle(c_wait[i]);
			compare_frames();
		end
	end

	if (chained && stall_max == 0) begin
		$display("no write was held back while a request was pending");
		bus_errs++;
	end
	$display("errors: value %0d, frame %0d, bus %0d, timing %0d, setup %0d",
		value_errs, frame_errs, bus_errs, timing_errs, setup_errs);
	if (value_errs + frame_errs + bus_errs + timing_errs + setup_errs == 0) begin
		$display("Everything OK");
	end else begin
		$display("Something failed");
	end
	$finish;
end

endmodule

//--- verification/tm1638_cases.txt
# op idx data wait mask back, all hex; op 0 cmd, 1 seg7, 2 led, 3 all leds, 4 buttons
# data 100 means a random byte; back 1 means written while the previous request runs
0 0 40 0 00 0
0 0 8f 3 00 0
1 0 3f 0 00 0
1 1 06 0 00 0
1 2 5b 0 00 0
1 3 4f 2 00 0
1 4 66 0 00 0
1 5 6d 0 00 0
1 6 7d 0 00 0
1 7 100 0 00 0
2 0 01 0 00 0
2 1 00 0 00 0
2 2 01 0 00 0
2 3 01 7 00 0
2 4 00 0 00 0
2 5 01 0 00 0
3 0 a5 0 00 0
3 0 100 5 00 0
4 0 00 0 00 0
4 0 00 0 81 0
4 0 00 a 5a 0
2 6 01 0 00 0
2 7 01 4 00 1
0 0 8a 20 00 1

//--- vlog.f
logic/tm1638_pkg.sv
logic/tm1638_serial.sv
logic/tm1638_led_key.sv
logic/tm1638_axil_regs.sv
logic/tm1638_shield_ctrl.sv
verification/tb_clock_gen.sv
verification/tm1638_chip_model.sv
verification/tb_tm1638_shield_ctrl.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := tb_tm1638_shield_ctrl
FILELIST  := vlog.f
OBJDIR    := obj_dir
PASS_MSG  := Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
